// ==== all.f ====
design/sgb_pkg.sv
design/sgb_packet_rx.sv
design/sgb_cmd_decoder.sv
design/sgb_palette_store.sv
design/sgb_joypad_port.sv
design/sgb_lcd_colorizer.sv
design/sgb_top.sv
verification/sgb_sva.sv
verification/tb_sgb.sv

// ==== Bender.yml ====
package:
  name: sgb

sources:
  - files:
      - design/sgb_pkg.sv
      - design/sgb_packet_rx.sv
      - design/sgb_cmd_decoder.sv
      - design/sgb_palette_store.sv
      - design/sgb_joypad_port.sv
      - design/sgb_lcd_colorizer.sv
      - design/sgb_top.sv
  - target: test
    files:
      - verification/sgb_sva.sv
      - verification/tb_sgb.sv

// ==== verification/tb_sgb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sgb import sgb_pkg::*; ;

	logic       clk_sys;
	logic       reset;
	logic       sgb_en;
	logic       tint;
	logic [1:0] joy_p54;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic [7:0] joystick_2;
	logic [7:0] joystick_3;
	lcd_pix_t   lcd_in;
	logic [3:0] joy_do;
	logic       sgb_pal_en;
	lcd_pix_t   lcd_out;

	logic [31:0] lfsr;
	logic [7:0]  pkt [16];
	int          lcd_errs;
	int          joy_errs;
	int          pal_en_errs;
	int          other_errs;

	// Reference model state
	color_t      m_pal [4][4];
	logic        m_active;
	mask_e       m_mask;
	logic [1:0]  m_mlt;
	logic [1:0]  m_prev;
	logic        m_locked;
	logic [1:0]  m_id;
	logic        m_idout;

	// Joypad state as the port shows it in the current cycle
	logic [1:0]  m_id_q;
	logic        m_idout_q;

	sgb_top #(
		.NUM_PLAYERS (4)
	) u_sgb_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sgb_en     (sgb_en),
		.tint       (tint),
		.joy_p54    (joy_p54),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joystick_2 (joystick_2),
		.joystick_3 (joystick_3),
		.lcd_in     (lcd_in),
		.joy_do     (joy_do),
		.sgb_pal_en (sgb_pal_en),
		.lcd_out    (lcd_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Taps 32, 22, 2, 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], next_bit()};
		return r;
	endfunction

	task automatic check_lcd(input string name, input lcd_pix_t exp, input lcd_pix_t act);
		if (act !== exp) begin
			lcd_errs++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_joy(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			joy_errs++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_pal_en(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			pal_en_errs++;
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	function automatic lcd_pix_t expect_pix(input lcd_pix_t px);
		lcd_pix_t o;
		o = px;
		if (!sgb_en || (m_mask == MASK_OFF && (!m_active || tint)))
			o.data = px.data;
		else if (m_mask == MASK_BLACK)
			o.data = '0;
		else if (m_mask == MASK_COLOR0 || px.data[1:0] == 2'd0)
			o.data = m_pal[0][0];
		else
			o.data = m_pal[0][px.data[1:0]];
		if (m_mask == MASK_FREEZE)
			o.clkena = 1'b0;
		return o;
	endfunction

	function automatic logic [3:0] expect_joy();
		logic [7:0] j;
		logic [3:0] dir;
		logic [3:0] btn;
		if (m_idout_q)
			return {2'b11, m_id_q};
		if (sgb_en && m_mlt[0])
			j = (m_id_q == 2'd3) ? joystick_0 : (m_id_q == 2'd2) ? joystick_1 :
				(m_id_q == 2'd1) ? joystick_2 : joystick_3;
		else
			j = joystick_0 | joystick_1;
		dir = ~{j[2], j[3], j[1], j[0]} | {4{joy_p54[0]}};
		btn = ~j[7:4] | {4{joy_p54[1]}};
		return dir & btn;
	endfunction

	// Drives the select lines and steps the joypad model with them
	task automatic step_lines(input logic [1:0] v);
		logic rise;
		logic pfall;
		@(posedge clk_sys);
		#1;
		m_id_q = m_id;
		m_idout_q = m_idout;
		joy_p54 = v;
		rise = sgb_en && m_prev != 2'b11 && v == 2'b11;
		pfall = m_prev[1] && !v[1] && v[0];
		if (rise && !m_locked) begin
			m_locked = 1'b1;
			m_idout = 1'b1;
			if (m_mlt == 2'd3)
				m_id = m_id - 2'd1;
			else if (m_mlt[0])
				m_id = {1'b1, ~m_id[0]};
			else
				m_id = 2'd3;
		end
		if (pfall)
			m_locked = !m_locked;
		if (v != 2'b11)
			m_idout = 1'b0;
		m_prev = v;
	endtask

	task automatic send_packet(input sgb_cmd_e cmd);
		pkt[0] = {cmd, 3'd1};
		step_lines(2'b00);
		step_lines(2'b11);
		for (int b = 0; b < BYTES_PER_PACKET; b++) begin
			for (int i = 0; i < 8; i++) begin
				step_lines(pkt[b][i] ? 2'b01 : 2'b10);
				step_lines(2'b11);
			end
			if (b == 1 && cmd == CMD_MLT_REQ)
				m_mlt = pkt[1][1:0];
		end
		if (cmd == CMD_MASK_EN)
			m_mask = mask_e'(pkt[1][1:0]);
		repeat (4) step_lines(2'b11);
	endtask

	task automatic apply_palette(input sgb_cmd_e cmd);
		logic [1:0] first;
		logic [1:0] second;
		color_t     c;
		first = (cmd == CMD_PAL23) ? 2'd2 : (cmd == CMD_PAL12) ? 2'd1 : 2'd0;
		second = (cmd == CMD_PAL01) ? 2'd1 : (cmd == CMD_PAL12) ? 2'd2 : 2'd3;
		for (int k = 0; k < 7; k++) begin
			c = {pkt[2 * k + 2][6:0], pkt[2 * k + 1]};
			if (k == 0)
				m_pal[0][0] = c;
			else if (k < 4)
				m_pal[first][k] = c;
			else
				m_pal[second][k - 3] = c;
		end
		m_active = 1'b1;
	endtask

	task automatic wait_pal_en();
		int n;
		n = 0;
		while (sgb_pal_en !== 1'b1 && n < 64) begin
			@(negedge clk_sys);
			n++;
		end
		if (sgb_pal_en !== 1'b1) begin
			other_errs++;
			$display("Timeout: sgb_pal_en did not rise after a palette packet");
		end
	endtask

	// Two pixels in flight
	task automatic run_pixels(input string name, input int count);
		lcd_pix_t exp_q [$];
		logic     en_q [$];
		lcd_pix_t px;
		for (int i = 0; i < count + 2; i++) begin
			@(posedge clk_sys);
			#1;
			if (i < count) begin
				px = lcd_pix_t'(rand_bits(19));
				lcd_in = px;
				exp_q.push_back(expect_pix(px));
				en_q.push_back(sgb_en && (m_active || m_mask != MASK_OFF));
			end
			@(negedge clk_sys);
			if (i >= 2) begin
				check_lcd(name, exp_q.pop_front(), lcd_out);
				check_pal_en(name, en_q.pop_front(), sgb_pal_en);
			end
		end
	endtask

	task automatic joy_round(input string name);
		logic [1:0] seq [3];
		seq[0] = 2'b10;
		seq[1] = 2'b01;
		seq[2] = 2'b11;
		for (int s = 0; s < 3; s++) begin
			step_lines(seq[s]);
			joystick_0 = 8'(rand_bits(8));
			joystick_1 = 8'(rand_bits(8));
			joystick_2 = 8'(rand_bits(8));
			joystick_3 = 8'(rand_bits(8));
			@(negedge clk_sys);
			check_joy(name, expect_joy(), joy_do);
		end
	endtask

	task automatic send_mlt(input logic [1:0] v);
		for (int b = 0; b < 16; b++)
			pkt[b] = 8'h00;
		pkt[1] = {6'd0, v};
		send_packet(CMD_MLT_REQ);
	endtask

	initial begin
		mask_e masks [4];
		sgb_cmd_e cmd;
		color_t c;
		lfsr = 32'hcc0439ee;
		lcd_errs = 0;
		joy_errs = 0;
		pal_en_errs = 0;
		other_errs = 0;
		reset = 1'b1;
		sgb_en = 1'b1;
		tint = 1'b0;
		joy_p54 = 2'b11;
		joystick_0 = '0;
		joystick_1 = '0;
		joystick_2 = '0;
		joystick_3 = '0;
		lcd_in = '0;
		for (int p = 0; p < 4; p++)
			for (int k = 0; k < 4; k++)
				m_pal[p][k] = '0;
		m_active = 1'b0;
		m_mask = MASK_OFF;
		m_mlt = 2'd0;
		m_prev = 2'b11;
		m_locked = 1'b0;
		m_id = 2'd0;
		m_idout = 1'b0;
		m_id_q = 2'd0;
		m_idout_q = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		run_pixels("reset_pass", 20);

		repeat (4) begin
			cmd = sgb_cmd_e'(rand_bits(2));
			for (int k = 0; k < 7; k++) begin
				c = color_t'(rand_bits(15));
				pkt[2 * k + 1] = c[7:0];
				pkt[2 * k + 2] = {next_bit(), c[14:8]};
			end
			pkt[15] = 8'(rand_bits(8));
			send_packet(cmd);
			apply_palette(cmd);
			wait_pal_en();
			run_pixels("palette", 24);
		end

		masks[0] = MASK_FREEZE;
		masks[1] = MASK_BLACK;
		masks[2] = MASK_COLOR0;
		masks[3] = MASK_OFF;
		for (int m = 0; m < 4; m++) begin
			for (int b = 0; b < 16; b++)
				pkt[b] = 8'h00;
			pkt[1] = {6'd0, masks[m]};
			send_packet(CMD_MASK_EN);
			run_pixels("mask", 16);
		end

		@(posedge clk_sys);
		#1;
		tint = 1'b1;
		run_pixels("tint_pass", 12);
		@(posedge clk_sys);
		#1;
		tint = 1'b0;
		sgb_en = 1'b0;
		run_pixels("sgb_off_pass", 12);
		@(posedge clk_sys);
		#1;
		sgb_en = 1'b1;

		repeat (2) joy_round("joy_single");
		send_mlt(2'd3);
		repeat (8) joy_round("joy_mlt4");
		send_mlt(2'd1);
		repeat (6) joy_round("joy_mlt2");

		repeat (4) @(posedge clk_sys);
		$display("Errors: lcd %0d, joy %0d, pal_en %0d, other %0d",
			lcd_errs, joy_errs, pal_en_errs, other_errs);
		if (lcd_errs + joy_errs + pal_en_errs + other_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/sgb_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_sva import sgb_pkg::*; (
	input logic       clk_sys,
	input logic       reset,
	input logic       byte_valid,
	input logic       pal_wr,
	input mask_e      mask,
	input lcd_pix_t   lcd_out,
	input logic [3:0] joy_do
);

	// Strobes cleared from the first reset edge on
	assert property (@(posedge clk_sys) reset |=> !pal_wr && !byte_valid)
		else $error("strobe active during reset");

	// Mask reaches the output two cycles later
	assert property (@(posedge clk_sys) disable iff (reset)
		mask == MASK_FREEZE |-> ##2 !lcd_out.clkena)
		else $error("clkena high under freeze mask");

	assert property (@(posedge clk_sys) disable iff (reset) !$isunknown(joy_do))
		else $error("joy_do unknown");

endmodule

bind sgb_top sgb_sva u_sgb_sva (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.byte_valid (byte_valid),
	.pal_wr     (pal_wr),
	.mask       (mask),
	.lcd_out    (lcd_out),
	.joy_do     (joy_do)
);

`default_nettype wire

// ==== design/sgb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_top import sgb_pkg::*; #(
	parameter int NUM_PLAYERS = 2
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sgb_en,
	input  logic       tint,
	input  logic [1:0] joy_p54,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [7:0] joystick_2,
	input  logic [7:0] joystick_3,
	input  lcd_pix_t   lcd_in,
	output logic [3:0] joy_do,
	output logic       sgb_pal_en,
	output lcd_pix_t   lcd_out
);

	logic         byte_valid;
	sgb_byte_t    rx_byte;
	logic         line_rise;
	logic         p15_fall;
	logic         pal_wr;
	pal_wr_t      pal_wr_data;
	logic [1:0]   mlt_ctrl;
	mask_e        mask;
	color_t [3:0] pal0;
	logic         pal_active;

	sgb_packet_rx u_packet_rx (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sgb_en     (sgb_en),
		.joy_p54    (joy_p54),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.line_rise  (line_rise),
		.p15_fall   (p15_fall)
	);

	sgb_cmd_decoder u_cmd_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.byte_valid  (byte_valid),
		.rx_byte     (rx_byte),
		.pal_wr      (pal_wr),
		.pal_wr_data (pal_wr_data),
		.mlt_ctrl    (mlt_ctrl),
		.mask        (mask)
	);

	sgb_palette_store u_palette_store (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pal_wr      (pal_wr),
		.pal_wr_data (pal_wr_data),
		.pal0        (pal0),
		.pal_active  (pal_active)
	);

	sgb_joypad_port #(
		.NUM_PLAYERS (NUM_PLAYERS)
	) u_joypad_port (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sgb_en     (sgb_en),
		.joy_p54    (joy_p54),
		.line_rise  (line_rise),
		.p15_fall   (p15_fall),
		.mlt_ctrl   (mlt_ctrl),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joystick_2 (joystick_2),
		.joystick_3 (joystick_3),
		.joy_do     (joy_do)
	);

	sgb_lcd_colorizer u_lcd_colorizer (
		.clk_sys    (clk_sys),
		.sgb_en     (sgb_en),
		.tint       (tint),
		.mask       (mask),
		.pal_active (pal_active),
		.pal0       (pal0),
		.lcd_in     (lcd_in),
		.lcd_out    (lcd_out),
		.sgb_pal_en (sgb_pal_en)
	);

endmodule

`default_nettype wire

// ==== design/sgb_lcd_colorizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_lcd_colorizer import sgb_pkg::*; (
	input  logic         clk_sys,
	input  logic         sgb_en,
	input  logic         tint,
	input  mask_e        mask,
	input  logic         pal_active,
	input  color_t [3:0] pal0,
	input  lcd_pix_t     lcd_in,
	output lcd_pix_t     lcd_out,
	output logic         sgb_pal_en
);

	lcd_pix_t lcd_r;
	logic     pass_r;
	mask_e    mask_r;
	logic     pal_en_r;

	// Stage 1 samples the pixel and the controls together
	always_ff @(posedge clk_sys) begin
		lcd_r <= lcd_in;
		pass_r <= !sgb_en || ((!pal_active || tint) && mask == MASK_OFF);
		mask_r <= mask;
		pal_en_r <= sgb_en && (pal_active || mask != MASK_OFF);
	end

	// Stage 2 maps through palette 0
	always_ff @(posedge clk_sys) begin
		if (pass_r)
			lcd_out.data <= lcd_r.data;
		else if (mask_r == MASK_BLACK)
			lcd_out.data <= '0;
		else if (mask_r == MASK_COLOR0 || lcd_r.data[1:0] == 2'd0)
			lcd_out.data <= pal0[0];
		else
			lcd_out.data <= pal0[lcd_r.data[1:0]];

		lcd_out.clkena <= (mask_r == MASK_FREEZE) ? 1'b0 : lcd_r.clkena;
		lcd_out.mode <= lcd_r.mode;
		lcd_out.on <= lcd_r.on;
		sgb_pal_en <= pal_en_r;
	end

endmodule

`default_nettype wire

// ==== design/sgb_joypad_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_joypad_port #(
	parameter int NUM_PLAYERS = 2
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sgb_en,
	input  logic [1:0] joy_p54,
	input  logic       line_rise,
	input  logic       p15_fall,
	input  logic [1:0] mlt_ctrl,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [7:0] joystick_2,
	input  logic [7:0] joystick_3,
	output logic [3:0] joy_do
);

	// Ids count down from 3, so the forced-high bits set the wrap point
	localparam logic [1:0] ID_MASK = (NUM_PLAYERS == 4) ? 2'b11 : 2'b01;

	logic [1:0] joy_id;
	logic       id_out;
	logic       locked;
	logic [1:0] id_fill;
	logic [7:0] joystick;
	logic [3:0] joy_dir;
	logic [3:0] joy_btn;

	assign id_fill = ~(mlt_ctrl & ID_MASK);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_id <= '0;
			id_out <= 1'b0;
			locked <= 1'b0;
		end else begin
			if (line_rise && !locked) begin
				locked <= 1'b1;
				id_out <= 1'b1;
				joy_id <= (joy_id - 2'd1) | id_fill;
			end
			if (p15_fall)
				locked <= ~locked;
			if (!joy_p54[0] || !joy_p54[1])
				id_out <= 1'b0;
		end
	end

	always_comb begin
		if (!sgb_en || !mlt_ctrl[0]) begin
			joystick = joystick_0 | joystick_1;
		end else begin
			case (joy_id)
				2'd3: joystick = joystick_0;
				2'd2: joystick = joystick_1;
				2'd1: joystick = joystick_2;
				default: joystick = joystick_3;
			endcase
		end
	end

	// Active low nibbles, P14 low selects directions, P15 low buttons
	assign joy_dir = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{joy_p54[0]}};
	assign joy_btn = ~joystick[7:4] | {4{joy_p54[1]}};

	assign joy_do = id_out ? {2'b11, joy_id} : (joy_dir & joy_btn);

endmodule

`default_nettype wire

// ==== design/sgb_palette_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_palette_store import sgb_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         pal_wr,
	input  pal_wr_t      pal_wr_data,
	output color_t [3:0] pal0,
	output logic         pal_active
);

	color_t [3:0] palette [4];
	logic         clearing;
	logic [3:0]   clr_cnt;
	logic         wr_en;
	logic [1:0]   wr_pal;
	logic [1:0]   wr_col;
	color_t       wr_color;

	// Zero clear owns the write port after reset
	always_comb begin
		if (clearing) begin
			wr_en = 1'b1;
			wr_pal = clr_cnt[3:2];
			wr_col = clr_cnt[1:0];
			wr_color = '0;
		end else begin
			wr_en = pal_wr;
			wr_pal = pal_wr_data.pal_no;
			wr_col = pal_wr_data.col_no;
			wr_color = pal_wr_data.color;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing <= 1'b1;
			clr_cnt <= '0;
			pal_active <= 1'b0;
		end else if (clearing) begin
			clr_cnt <= clr_cnt + 4'd1;
			if (&clr_cnt)
				clearing <= 1'b0;
		end else if (pal_wr) begin
			pal_active <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			palette[wr_pal][wr_col] <= wr_color;
	end

	assign pal0 = palette[0];

endmodule

`default_nettype wire

// ==== design/sgb_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_cmd_decoder import sgb_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       byte_valid,
	input  sgb_byte_t  rx_byte,
	output logic       pal_wr,
	output pal_wr_t    pal_wr_data,
	output logic [1:0] mlt_ctrl,
	output mask_e      mask
);

	sgb_cmd_e   cmd;
	logic [7:0] color_lo;
	logic       pal_cmd;
	logic       pal_byte;
	logic       first_byte1;
	logic [2:0] col_idx;
	logic [1:0] pal_first;
	logic [1:0] pal_second;
	logic [1:0] tgt_pal;
	logic [1:0] tgt_col;

	assign pal_cmd = (cmd inside {CMD_PAL01, CMD_PAL23, CMD_PAL03, CMD_PAL12});
	assign pal_byte = pal_cmd && rx_byte.byte_no >= 4'd1 && rx_byte.byte_no <= 4'd14;
	assign first_byte1 = rx_byte.first_packet && rx_byte.byte_no == 4'd1;

	// Even bytes 2..14 close colors 0..6
	assign col_idx = rx_byte.byte_no[3:1] - 3'd1;

	always_comb begin
		case (cmd)
			CMD_PAL23: begin
				pal_first = 2'd2;
				pal_second = 2'd3;
			end
			CMD_PAL03: begin
				pal_first = 2'd0;
				pal_second = 2'd3;
			end
			CMD_PAL12: begin
				pal_first = 2'd1;
				pal_second = 2'd2;
			end
			default: begin
				pal_first = 2'd0;
				pal_second = 2'd1;
			end
		endcase

		// Color 0 is shared by all palettes
		if (col_idx == 3'd0) begin
			tgt_pal = 2'd0;
			tgt_col = 2'd0;
		end else if (col_idx < 3'd4) begin
			tgt_pal = pal_first;
			tgt_col = col_idx[1:0];
		end else begin
			tgt_pal = pal_second;
			tgt_col = 2'(col_idx - 3'd3);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd <= CMD_PAL01;
			pal_wr <= 1'b0;
			mlt_ctrl <= '0;
			mask <= MASK_OFF;
		end else begin
			pal_wr <= 1'b0;
			if (byte_valid) begin
				if (rx_byte.first_packet && rx_byte.byte_no == 4'd0)
					cmd <= sgb_cmd_e'(rx_byte.data[7:3]);
				if (pal_byte && !rx_byte.byte_no[0])
					pal_wr <= 1'b1;
				if (cmd == CMD_MLT_REQ && first_byte1)
					mlt_ctrl <= rx_byte.data[1:0];
				if (cmd == CMD_MASK_EN && first_byte1)
					mask <= mask_e'(rx_byte.data[1:0]);
			end
		end
	end

	// Low byte first
	always_ff @(posedge clk_sys) begin
		if (byte_valid && pal_byte) begin
			if (rx_byte.byte_no[0]) begin
				color_lo <= rx_byte.data;
			end else begin
				pal_wr_data.pal_no <= tgt_pal;
				pal_wr_data.col_no <= tgt_col;
				pal_wr_data.color <= {rx_byte.data[6:0], color_lo};
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/sgb_packet_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module sgb_packet_rx import sgb_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sgb_en,
	input  logic [1:0] joy_p54,
	output logic       byte_valid,
	output sgb_byte_t  rx_byte,
	output logic       line_rise,
	output logic       p15_fall
);

	logic       p14;
	logic       p15;
	logic [1:0] joy_prev;
	logic       sample_en;
	logic       data_bit;
	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic [3:0] byte_cnt;
	logic [2:0] packet_cnt;
	logic [2:0] packet_len;
	logic       pkt_open;

	assign p14 = joy_p54[0];
	assign p15 = joy_p54[1];

	// Both lines must have been high before a sample counts
	assign sample_en = joy_prev[0] & joy_prev[1] & sgb_en;
	assign data_bit = sample_en & (p14 ^ p15) & pkt_open;

	// Edge events for the joypad port
	assign line_rise = sgb_en & ~(joy_prev[0] & joy_prev[1]) & p14 & p15;
	assign p15_fall = joy_prev[1] & ~p15 & p14;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_prev <= 2'b11;
			bit_cnt <= '0;
			byte_cnt <= '0;
			packet_cnt <= '0;
			packet_len <= '0;
			pkt_open <= 1'b0;
			byte_valid <= 1'b0;
		end else begin
			joy_prev <= joy_p54;
			byte_valid <= 1'b0;

			// Reset pulse
			if (sample_en && !p14 && !p15) begin
				bit_cnt <= '0;
				byte_cnt <= '0;
				pkt_open <= 1'b1;
			end

			if (data_bit) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7)
					byte_valid <= 1'b1;
			end

			if (byte_valid) begin
				byte_cnt <= byte_cnt + 4'd1;
				if (packet_cnt == 3'd0 && byte_cnt == 4'd0)
					packet_len <= shift[2:0];

				// Last byte of a packet
				if (byte_cnt == 4'(BYTES_PER_PACKET - 1)) begin
					packet_cnt <= packet_cnt + 3'd1;
					if ({1'b0, packet_cnt} + 4'd1 >= {1'b0, packet_len}) begin
						packet_cnt <= '0;
						pkt_open <= 1'b0;
					end
				end
			end
		end
	end

	// LSB first, the bit is the inverse of P15
	always_ff @(posedge clk_sys) begin
		if (data_bit)
			shift <= {~p15, shift[7:1]};
	end

	assign rx_byte.data = shift;
	assign rx_byte.byte_no = byte_cnt;
	assign rx_byte.first_packet = (packet_cnt == 3'd0);

endmodule

`default_nettype wire

// ==== design/sgb_pkg.sv ====
`default_nettype none

package sgb_pkg;

	// Command codes still handled
	typedef enum logic [4:0] {
		CMD_PAL01   = 5'd0,
		CMD_PAL23   = 5'd1,
		CMD_PAL03   = 5'd2,
		CMD_PAL12   = 5'd3,
		CMD_MLT_REQ = 5'd17,
		CMD_MASK_EN = 5'd23
	} sgb_cmd_e;

	// BGR555
	localparam int COLOR_W = 15;
	typedef logic [COLOR_W-1:0] color_t;

	localparam int BYTES_PER_PACKET = 16;
	localparam int LCD_W = 15;

	typedef struct packed {
		logic [7:0] data;
		logic [3:0] byte_no;
		logic       first_packet;
	} sgb_byte_t;

	typedef struct packed {
		logic [1:0] pal_no;
		logic [1:0] col_no;
		color_t     color;
	} pal_wr_t;

	typedef struct packed {
		logic [LCD_W-1:0] data;
		logic             clkena;
		logic [1:0]       mode;
		logic             on;
	} lcd_pix_t;

	typedef enum logic [1:0] {
		MASK_OFF    = 2'd0,
		MASK_FREEZE = 2'd1,
		MASK_BLACK  = 2'd2,
		MASK_COLOR0 = 2'd3
	} mask_e;

endpackage

`default_nettype wire
